//--- design/gallery_pkg.sv
/*
 * Shared geometry and data types for the UART image gallery.
 * Modules refer to these by scoped names into the package.
 */

package gallery_pkg;

  // ==================================================
  // Image geometry
  // ==================================================
  localparam int IMG_W     = 16;
  localparam int IMG_H     = 16;
  localparam int NUM_SLOTS = 4;
  localparam int IMG_BYTES = IMG_W * IMG_H;
  localparam int MEM_BYTES = IMG_BYTES * NUM_SLOTS;

  // Thumbnail keeps every second pixel of every second row
  localparam int THUMB_W = IMG_W / 2;
  localparam int THUMB_H = IMG_H / 2;

  // ==================================================
  // Data types
  // ==================================================
  typedef logic [7:0]                   pixel_t;
  typedef logic [$clog2(MEM_BYTES)-1:0] mem_addr_t;
  typedef logic [$clog2(NUM_SLOTS)-1:0] slot_t;

endpackage

//--- design/wb_if.sv
/*
 * Wishbone classic bus, single byte transfers into the frame memory.
 * One instance per link between a master and a slave.
 */

`timescale 1ns/1ps

interface wb_if;

  logic                  cyc;
  logic                  stb;
  logic                  we;
  gallery_pkg::mem_addr_t adr;
  gallery_pkg::pixel_t   dat_w;
  gallery_pkg::pixel_t   dat_r;
  logic                  ack;

  // Master holds the request until ack comes back
  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );

endinterface

//--- design/uart_rx.sv
/*
 * UART receiver, 8N1, LSB first.
 * Produces one byte per frame with a single-cycle rx_valid at the
 * end of the stop bit. CLKS_PER_BIT sets the baud rate.
 */

`timescale 1ns/1ps

module uart_rx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                CLOCK_50,
  input  logic                DLY_RST_0,
  input  logic                rxd,
  output gallery_pkg::pixel_t rx_byte,
  output logic                rx_valid
);

  localparam int CNT_W = $clog2(2 * CLKS_PER_BIT);

  typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

  state_t              state;
  logic [1:0]          rxd_sync;
  logic                rxd_s;
  logic [CNT_W-1:0]    clk_cnt;
  logic [2:0]          bit_idx;
  logic                stop_ok;
  gallery_pkg::pixel_t shift;

  assign rxd_s   = rxd_sync[1];
  assign rx_byte = shift;

  // Two-flop synchronizer that resets to the idle high level
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      rxd_sync <= 2'b11;
    end else begin
      rxd_sync <= {rxd_sync[0], rxd};
    end
  end

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state    <= S_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      stop_ok  <= 1'b0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      clk_cnt  <= clk_cnt + 1'b1;
      case (state)
        S_IDLE: begin
          clk_cnt <= '0;
          if (!rxd_s) begin
            state <= S_START;
          end
        end
        // Recheck the line at mid start bit to reject glitches
        S_START: begin
          if (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rxd_s ? S_IDLE : S_DATA;
          end
        end
        S_DATA: begin
          if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= S_STOP;
            end
          end
        end
        S_STOP: begin
          if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            stop_ok <= rxd_s;
          end
          // Half a bit past mid stop
          if (clk_cnt == CNT_W'(CLKS_PER_BIT + CLKS_PER_BIT / 2 - 1)) begin
            rx_valid <= stop_ok;
            state    <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Data bits shift in from the top, so bit 0 ends up at the bottom
  always_ff @(posedge CLOCK_50) begin
    if (state == S_DATA && clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
      shift <= {rxd_s, shift[7:1]};
    end
  end

endmodule

//--- design/uart_tx.sv
/*
 * UART transmitter, 8N1, LSB first.
 * Pulse tx_start with tx_byte valid; tx_done pulses once the stop
 * bit has been sent. Start pulses while busy are ignored.
 */

`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                CLOCK_50,
  input  logic                DLY_RST_0,
  input  logic                tx_start,
  input  gallery_pkg::pixel_t tx_byte,
  output logic                txd,
  output logic                tx_done
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

  logic             busy;
  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_cnt;
  logic [8:0]       shreg;

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      busy    <= 1'b0;
      txd     <= 1'b1;
      tx_done <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      tx_done <= 1'b0;
      if (!busy) begin
        if (tx_start) begin
          // Start bit goes out right away
          busy    <= 1'b1;
          txd     <= 1'b0;
          clk_cnt <= '0;
          bit_cnt <= '0;
        end
      end else if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
        clk_cnt <= '0;
        if (bit_cnt == 4'd9) begin
          busy    <= 1'b0;
          tx_done <= 1'b1;
        end else begin
          txd     <= shreg[0];
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

  // Data bits then the stop bit shift out as ones refill the top
  always_ff @(posedge CLOCK_50) begin
    if (!busy && tx_start) begin
      shreg <= {1'b1, tx_byte};
    end else if (busy && clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
      shreg <= {1'b1, shreg[8:1]};
    end
  end

endmodule

//--- design/image_loader.sv
/*
 * Routes received bytes either into frame memory or to the slot register.
 * With load_mode high each byte becomes one Wishbone write at the
 * wrapping write pointer; otherwise its low bits select the slot.
 */

`timescale 1ns/1ps

module image_loader (
  input  logic                CLOCK_50,
  input  logic                DLY_RST_0,
  input  logic                load_mode,
  input  gallery_pkg::pixel_t rx_byte,
  input  logic                rx_valid,
  output gallery_pkg::slot_t  cur_slot,
  wb_if.master                bus
);

  localparam gallery_pkg::mem_addr_t LAST_ADDR =
    gallery_pkg::mem_addr_t'(gallery_pkg::MEM_BYTES - 1);

  gallery_pkg::mem_addr_t wr_ptr;
  gallery_pkg::pixel_t    pend_byte;
  logic                   wr_busy;

  // Write-only master
  assign bus.cyc   = wr_busy;
  assign bus.stb   = wr_busy;
  assign bus.we    = 1'b1;
  assign bus.adr   = wr_ptr;
  assign bus.dat_w = pend_byte;

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      wr_busy  <= 1'b0;
      wr_ptr   <= '0;
      cur_slot <= '0;
    end else begin
      if (wr_busy && bus.ack) begin
        wr_busy <= 1'b0;
        wr_ptr  <= (wr_ptr == LAST_ADDR) ? '0 : wr_ptr + 1'b1;
      end
      // A byte frame is far longer than one access, so no overlap
      if (rx_valid) begin
        if (load_mode) begin
          wr_busy <= 1'b1;
        end else begin
          cur_slot <= rx_byte[$bits(gallery_pkg::slot_t)-1:0];
        end
      end
    end
  end

  always_ff @(posedge CLOCK_50) begin
    if (rx_valid && load_mode) begin
      pend_byte <= rx_byte;
    end
  end

endmodule

//--- design/wb_arbiter.sv
/*
 * Two-master Wishbone classic arbiter in front of the frame memory.
 * m0 wins when both request. The grant is registered and held until
 * the granted master drops cyc; the other master stalls without ack.
 */

`timescale 1ns/1ps

module wb_arbiter (
  input  logic CLOCK_50,
  input  logic DLY_RST_0,
  wb_if.slave  m0,
  wb_if.slave  m1,
  wb_if.master mem
);

  logic busy;
  logic gnt;
  logic sel_cyc;
  logic sel_stb;

  // ==================================================
  // Grant register
  // ==================================================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      busy <= 1'b0;
      gnt  <= 1'b0;
    end else if (!busy) begin
      if (m0.cyc && m0.stb) begin
        busy <= 1'b1;
        gnt  <= 1'b0;
      end else if (m1.cyc && m1.stb) begin
        busy <= 1'b1;
        gnt  <= 1'b1;
      end
    end else if (!sel_cyc) begin
      busy <= 1'b0;
    end
  end

  // ==================================================
  // Bus mux
  // ==================================================
  assign sel_cyc = gnt ? m1.cyc : m0.cyc;
  assign sel_stb = gnt ? m1.stb : m0.stb;

  assign mem.cyc   = busy && sel_cyc;
  assign mem.stb   = busy && sel_stb;
  assign mem.we    = gnt ? m1.we    : m0.we;
  assign mem.adr   = gnt ? m1.adr   : m0.adr;
  assign mem.dat_w = gnt ? m1.dat_w : m0.dat_w;

  // Only the granted master sees the response
  assign m0.ack   = busy && !gnt && mem.ack;
  assign m1.ack   = busy && gnt && mem.ack;
  assign m0.dat_r = (busy && !gnt) ? mem.dat_r : '0;
  assign m1.dat_r = (busy && gnt) ? mem.dat_r : '0;

endmodule

//--- design/frame_ram.sv
/*
 * Frame memory for all image slots, as a Wishbone classic slave.
 * Each access is acknowledged one clock after the request is seen;
 * read data is valid together with ack.
 */

`timescale 1ns/1ps

module frame_ram (
  input  logic CLOCK_50,
  input  logic DLY_RST_0,
  wb_if.slave  bus
);

  gallery_pkg::pixel_t mem [gallery_pkg::MEM_BYTES];

  logic req;

  // New request only while no ack is out
  assign req = bus.cyc && bus.stb && !bus.ack;

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= req;
    end
  end

  always_ff @(posedge CLOCK_50) begin
    if (req && bus.we) begin
      mem[bus.adr] <= bus.dat_w;
    end
    bus.dat_r <= mem[bus.adr];
  end

endmodule

//--- design/thumb_streamer.sv
/*
 * Streams a 2:1 decimated thumbnail of one slot to the UART transmitter.
 * A rising edge of send_req while idle latches cur_slot; each kept pixel
 * is read over Wishbone, sent, and tx_done is awaited before the next.
 */

`timescale 1ns/1ps

module thumb_streamer (
  input  logic                CLOCK_50,
  input  logic                DLY_RST_0,
  input  logic                send_req,
  input  gallery_pkg::slot_t  cur_slot,
  input  logic                tx_done,
  output logic                tx_start,
  output gallery_pkg::pixel_t tx_byte,
  output logic                sending,
  wb_if.master                bus
);

  localparam int COL_W = $clog2(gallery_pkg::THUMB_W);
  localparam int ROW_W = $clog2(gallery_pkg::THUMB_H);

  typedef enum logic [1:0] {S_IDLE, S_READ, S_SEND, S_WAIT} state_t;

  state_t              state;
  logic                req_d;
  logic                rd_cyc;
  logic [COL_W-1:0]    col;
  logic [ROW_W-1:0]    row;
  gallery_pkg::slot_t  slot_q;
  gallery_pkg::pixel_t pix_q;
  logic                last_pix;

  // Slot base + 2r rows + 2c columns
  assign bus.adr = gallery_pkg::mem_addr_t'(int'(slot_q) * gallery_pkg::IMG_BYTES
                 + int'(row) * 2 * gallery_pkg::IMG_W + int'(col) * 2);
  assign bus.cyc   = rd_cyc;
  assign bus.stb   = rd_cyc;
  assign bus.we    = 1'b0;
  assign bus.dat_w = '0;

  assign tx_start = (state == S_SEND);
  assign tx_byte  = pix_q;
  assign last_pix = (row == ROW_W'(gallery_pkg::THUMB_H - 1)) &&
                    (col == COL_W'(gallery_pkg::THUMB_W - 1));

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state   <= S_IDLE;
      req_d   <= 1'b0;
      rd_cyc  <= 1'b0;
      sending <= 1'b0;
      row     <= '0;
      col     <= '0;
      slot_q  <= '0;
    end else begin
      req_d <= send_req;
      case (state)
        S_IDLE: begin
          if (send_req && !req_d) begin
            slot_q  <= cur_slot;
            row     <= '0;
            col     <= '0;
            sending <= 1'b1;
            rd_cyc  <= 1'b1;
            state   <= S_READ;
          end
        end
        S_READ: begin
          if (bus.ack) begin
            rd_cyc <= 1'b0;
            state  <= S_SEND;
          end
        end
        // tx_start is high for exactly this one cycle
        S_SEND: state <= S_WAIT;
        S_WAIT: begin
          if (tx_done) begin
            if (last_pix) begin
              sending <= 1'b0;
              state   <= S_IDLE;
            end else begin
              col    <= col + 1'b1;
              row    <= (col == COL_W'(gallery_pkg::THUMB_W - 1)) ? row + 1'b1 : row;
              rd_cyc <= 1'b1;
              state  <= S_READ;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLOCK_50) begin
    if (state == S_READ && bus.ack) begin
      pix_q <= bus.dat_r;
    end
  end

endmodule

//--- design/gallery_top.sv
/*
 * UART image gallery top level.
 * Bytes on uart_rxd load image slots or select the current slot;
 * a send_req edge returns a thumbnail of that slot on uart_txd.
 * CLKS_PER_BIT sets the UART bit time for both directions.
 */

`timescale 1ns/1ps

module gallery_top #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic               CLOCK_50,
  input  logic               DLY_RST_0,
  input  logic               uart_rxd,
  input  logic               load_mode,
  input  logic               send_req,
  output logic               uart_txd,
  output logic               sending,
  output gallery_pkg::slot_t cur_slot
);

  gallery_pkg::pixel_t rx_byte;
  logic                rx_valid;
  gallery_pkg::pixel_t tx_byte;
  logic                tx_start;
  logic                tx_done;

  wb_if loader_bus ();
  wb_if stream_bus ();
  wb_if mem_bus ();

  // ==================================================
  // Serial side
  // ==================================================
  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_rx (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .rxd       (uart_rxd),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_tx (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .txd       (uart_txd),
    .tx_done   (tx_done)
  );

  // ==================================================
  // Memory peers
  // ==================================================
  image_loader u_loader (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .load_mode (load_mode),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid),
    .cur_slot  (cur_slot),
    .bus       (loader_bus.master)
  );

  thumb_streamer u_streamer (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .send_req  (send_req),
    .cur_slot  (cur_slot),
    .tx_done   (tx_done),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .sending   (sending),
    .bus       (stream_bus.master)
  );

  // Loader has priority over the streamer
  wb_arbiter u_arb (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .m0        (loader_bus.slave),
    .m1        (stream_bus.slave),
    .mem       (mem_bus.master)
  );

  frame_ram u_ram (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .bus       (mem_bus.slave)
  );

endmodule

//--- verif/tb_gallery.sv
/*
 * Testbench for the UART image gallery.
 * Loads random images over uart_rxd, selects slots and checks every
 * returned thumbnail against a byte model of the frame memory.
 */

`timescale 1ns/1ps

module tb_gallery;

  localparam int CLKS_PER_BIT = 8;
  // Receive frame is 10 bits plus one idle bit
  localparam int FRAME_CYC    = 11 * CLKS_PER_BIT;
  localparam int THUMB_BYTES  = gallery_pkg::THUMB_W * gallery_pkg::THUMB_H;
  localparam int IDLE_BITS    = 20;
  localparam int NUM_LOADS    = 3 * gallery_pkg::IMG_BYTES;
  localparam int NUM_SELECTS  = 6;
  localparam int NUM_THUMBS   = 5;
  localparam int TEST_CYC     = FRAME_CYC * (NUM_LOADS + NUM_SELECTS + NUM_THUMBS * THUMB_BYTES)
                              + NUM_THUMBS * IDLE_BITS * CLKS_PER_BIT;
  localparam int TIMEOUT_CYC  = 2 * TEST_CYC;

  logic               CLOCK_50;
  logic               DLY_RST_0;
  logic               uart_rxd;
  logic               load_mode;
  logic               send_req;
  logic               uart_txd;
  logic               sending;
  gallery_pkg::slot_t cur_slot;

  // Reference model
  gallery_pkg::pixel_t model_mem [gallery_pkg::MEM_BYTES];
  int                  model_ptr;
  gallery_pkg::slot_t  model_slot;

  gallery_pkg::pixel_t thumb_q [$];
  logic [15:0]         lfsr_state;
  int                  cycle_cnt;

  gallery_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) UUT (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .uart_rxd  (uart_rxd),
    .load_mode (load_mode),
    .send_req  (send_req),
    .uart_txd  (uart_txd),
    .sending   (sending),
    .cur_slot  (cur_slot)
  );

  always #5 CLOCK_50 = ~CLOCK_50;

  always @(posedge CLOCK_50) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      fail_now($sformatf("Run timed out after %0d clock cycles", cycle_cnt));
    end
  end

  // ==================================================
  // Random bytes and result checks
  // ==================================================
  // Taps 16, 15, 13, 4
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
  endfunction

  function automatic gallery_pkg::pixel_t rand_byte();
    gallery_pkg::pixel_t b;
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      b[i] = lfsr_state[0];
    end
    return b;
  endfunction

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_pixel(input string name, input gallery_pkg::pixel_t got,
                             input gallery_pkg::pixel_t exp);
    if (got !== exp) begin
      fail_now($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_slot(input string name, input gallery_pkg::slot_t got,
                            input gallery_pkg::slot_t exp);
    if (got !== exp) begin
      fail_now($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // ==================================================
  // UART driver and monitor
  // ==================================================
  task automatic drive_bit(input logic b);
    @(posedge CLOCK_50);
    uart_rxd <= b;
    repeat (CLKS_PER_BIT - 1) @(posedge CLOCK_50);
  endtask

  task automatic send_uart_byte(input gallery_pkg::pixel_t b);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(b[i]);
    end
    drive_bit(1'b1);
    // Idle bit between frames
    drive_bit(1'b1);
  endtask

  // Samples each bit mid period on the falling edge
  task automatic recv_uart_byte(output gallery_pkg::pixel_t b);
    while (uart_txd !== 1'b0) @(negedge CLOCK_50);
    repeat (CLKS_PER_BIT / 2) @(negedge CLOCK_50);
    check_bit("uart_txd start bit", uart_txd, 1'b0);
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge CLOCK_50);
      b[i] = uart_txd;
    end
    repeat (CLKS_PER_BIT) @(negedge CLOCK_50);
    check_bit("uart_txd stop bit", uart_txd, 1'b1);
  endtask

  initial begin
    gallery_pkg::pixel_t b;
    @(posedge DLY_RST_0);
    forever begin
      recv_uart_byte(b);
      thumb_q.push_back(b);
    end
  end

  // ==================================================
  // Test steps
  // ==================================================
  task automatic load_bytes(input int n);
    gallery_pkg::pixel_t b;
    for (int i = 0; i < n; i++) begin
      b = rand_byte();
      model_mem[model_ptr] = b;
      model_ptr = (model_ptr + 1) % gallery_pkg::MEM_BYTES;
      send_uart_byte(b);
    end
  endtask

  task automatic select_slot(input gallery_pkg::pixel_t b);
    send_uart_byte(b);
    model_slot = b[$bits(gallery_pkg::slot_t)-1:0];
    @(negedge CLOCK_50);
    check_slot("cur_slot", cur_slot, model_slot);
  endtask

  task automatic pulse_req();
    @(posedge CLOCK_50);
    send_req <= 1'b1;
    repeat (2) @(posedge CLOCK_50);
    send_req <= 1'b0;
  endtask

  task automatic start_thumb();
    thumb_q.delete();
    pulse_req();
    while (!sending) @(negedge CLOCK_50);
  endtask

  // Expected byte sits at slot base + 2r rows + 2c columns
  task automatic finish_thumb(input gallery_pkg::slot_t slot);
    int addr;
    int idx;
    while (sending) @(negedge CLOCK_50);
    repeat (IDLE_BITS * CLKS_PER_BIT) @(negedge CLOCK_50);
    check_bit("sending", sending, 1'b0);
    if (thumb_q.size() != THUMB_BYTES) begin
      fail_now($sformatf("Thumbnail of slot %0d had %0d bytes instead of %0d",
                         slot, thumb_q.size(), THUMB_BYTES));
    end
    idx = 0;
    for (int r = 0; r < gallery_pkg::THUMB_H; r++) begin
      for (int c = 0; c < gallery_pkg::THUMB_W; c++) begin
        addr = int'(slot) * gallery_pkg::IMG_BYTES + 2 * r * gallery_pkg::IMG_W + 2 * c;
        check_pixel($sformatf("uart_txd byte %0d", idx), thumb_q[idx], model_mem[addr]);
        idx++;
      end
    end
  endtask

  initial begin
    CLOCK_50   = 1'b0;
    DLY_RST_0  = 1'b0;
    uart_rxd   = 1'b1;
    load_mode  = 1'b0;
    send_req   = 1'b0;
    lfsr_state = 16'd32738;
    model_ptr  = 0;
    model_slot = '0;
    cycle_cnt  = 0;
    repeat (5) @(posedge CLOCK_50);
    DLY_RST_0 <= 1'b1;

    // Idle outputs right after reset
    @(negedge CLOCK_50);
    check_bit("uart_txd", uart_txd, 1'b1);
    check_bit("sending", sending, 1'b0);
    check_slot("cur_slot", cur_slot, 2'd0);

    // Fill slots 0 and 1, then select with byte 5
    @(posedge CLOCK_50);
    load_mode <= 1'b1;
    load_bytes(2 * gallery_pkg::IMG_BYTES);
    @(posedge CLOCK_50);
    load_mode <= 1'b0;
    select_slot(8'd5);

    start_thumb();
    finish_thumb(model_slot);

    // Second request mid transfer must be ignored
    start_thumb();
    repeat (20 * CLKS_PER_BIT) @(posedge CLOCK_50);
    pulse_req();
    @(negedge CLOCK_50);
    check_bit("sending", sending, 1'b1);
    finish_thumb(model_slot);

    // Select bytes leave memory untouched
    repeat (3) select_slot(rand_byte());
    select_slot(rand_byte() & 8'hFC);
    start_thumb();
    finish_thumb(model_slot);

    // ==================================================
    // Loader and streamer share the memory
    // ==================================================
    @(posedge CLOCK_50);
    load_mode <= 1'b1;
    fork
      load_bytes(gallery_pkg::IMG_BYTES);
      begin
        start_thumb();
        finish_thumb(2'd0);
      end
    join
    @(posedge CLOCK_50);
    load_mode <= 1'b0;
    select_slot(8'd2);
    start_thumb();
    finish_thumb(model_slot);

    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- flist.f
design/gallery_pkg.sv
design/wb_if.sv
design/uart_rx.sv
design/uart_tx.sv
design/image_loader.sv
design/wb_arbiter.sv
design/frame_ram.sv
design/thumb_streamer.sv
design/gallery_top.sv
verif/tb_gallery.sv

//--- Bender.yml
package:
  name: uart_gallery

sources:
  - files:
      - design/gallery_pkg.sv
      - design/wb_if.sv
      - design/uart_rx.sv
      - design/uart_tx.sv
      - design/image_loader.sv
      - design/wb_arbiter.sv
      - design/frame_ram.sv
      - design/thumb_streamer.sv
      - design/gallery_top.sv
  - target: test
    files:
      - verif/tb_gallery.sv
